// File: Bender.yml
package:
  name: vstu

sources:
  - include_dirs:
      - design
    files:
      - design/vstu_pkg.sv
      - design/store_insn_queue.sv
      - design/lane_operand_buffer.sv
      - design/w_beat_packer.sv
      - design/vstu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_vstu.sv

// File: design/lane_operand_buffer.sv
// A lane holds at most one operand; all lanes are released together by word_ready_i
`timescale 1ns/1ps
`include "vstu_consts.svh"

module lane_operand_buffer (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // Lane side
  input  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_BYTES*8-1:0] operand_i,
  input  logic [`VSTU_NR_LANES-1:0]                        operand_valid_i,
  output logic [`VSTU_NR_LANES-1:0]                        operand_ready_o,
  // Packer side
  output vstu_pkg::vrf_word_t                              word_o,
  output logic                                             word_valid_o,
  input  logic                                             word_ready_i
);
  import vstu_pkg::*;

  localparam int unsigned LANES  = `VSTU_NR_LANES;
  localparam int unsigned LANE_W = `VSTU_LANE_BYTES * 8;

  logic [LANES-1:0] lane_valid;
  vrf_word_t        word_join;

  //////////////////////////////////////////////////////////////////////
  // Per-lane fall-through registers
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < LANES; l++) begin : gen_lane
    logic              full_q;
    logic [LANE_W-1:0] data_q;

    // Empty register passes the lane straight through
    assign lane_valid[l]                  = full_q || operand_valid_i[l];
    assign word_join[LANE_W*l +: LANE_W]  = full_q ? data_q : operand_i[l];
    assign operand_ready_o[l]             = !full_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        full_q <= 1'b0;
      end else if (word_ready_i) begin
        // Taken, either from storage or on the fly
        full_q <= 1'b0;
      end else if (operand_valid_i[l]) begin
        // Park it until the other lanes catch up
        full_q <= 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (!full_q && operand_valid_i[l]) begin
        data_q <= operand_i[l];
      end
    end
  end

  // Word is complete once every lane has something
  assign word_valid_o = &lane_valid;
  assign word_o       = word_join;

  // Pending word stays put until taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (word_valid_o && !word_ready_i) |=> (word_valid_o && $stable(word_o)))
    else $error("operand word changed before it was taken");

endmodule

// File: design/store_insn_queue.sv
// Ids must stay set on running_i while in flight; one B per store, answered in issue order
`timescale 1ns/1ps
`include "vstu_consts.svh"

module store_insn_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer side
  input  vstu_pkg::store_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  vstu_pkg::done_vec_t  running_i,
  // Packer side
  output vstu_pkg::store_req_t issue_o,
  output logic                 issue_valid_o,
  input  logic                 issue_done_i,
  // Memory B channel
  input  logic                 b_valid_i,
  output logic                 b_ready_o,
  // Status
  output logic                 store_pending_o,
  output logic                 store_complete_o,
  output vstu_pkg::done_vec_t  done_o
);
  import vstu_pkg::*;

  localparam int unsigned DEPTH = `VSTU_QUEUE_DEPTH;
  localparam int unsigned PNT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  //////////////////////////////////////////////////////////////////////
  // Queue state
  //////////////////////////////////////////////////////////////////////

  // Entry storage
  store_req_t entries_q [DEPTH];

  // Accept, issue and commit pointers
  logic [PNT_W-1:0] accept_pnt_q;
  logic [PNT_W-1:0] issue_pnt_q;
  logic [PNT_W-1:0] commit_pnt_q;

  // Entries waiting for issue, and entries not yet committed
  logic [CNT_W-1:0] issue_cnt_q, issue_cnt_d;
  logic [CNT_W-1:0] commit_cnt_q, commit_cnt_d;

  // Ids held here until the sequencer retires them
  done_vec_t running_q, running_d;
  done_vec_t done_q, done_d;

  logic req_ready_q;
  logic accept;
  logic b_fire;

  // Circular increment
  function automatic logic [PNT_W-1:0] bump(input logic [PNT_W-1:0] pnt);
    logic [PNT_W-1:0] nxt;
    if (pnt == PNT_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = pnt + 1'b1;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  // Id guard only blocks the accept, never the ready
  assign accept      = req_valid_i && req_ready_q && !running_q[req_i.id];
  assign req_ready_o = req_ready_q;

  // Head of the issue phase
  assign issue_o       = entries_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  // Something issued and still waiting for B
  assign b_ready_o        = (commit_cnt_q != issue_cnt_q);
  assign b_fire           = b_valid_i && b_ready_o;
  assign store_complete_o = b_fire;
  assign store_pending_o  = (commit_cnt_q != '0);
  assign done_o           = done_q;

  always_comb begin : p_next
    issue_cnt_d  = issue_cnt_q + CNT_W'(accept) - CNT_W'(issue_done_i);
    commit_cnt_d = commit_cnt_q + CNT_W'(accept) - CNT_W'(b_fire);
    // Drop ids the sequencer no longer runs
    running_d = running_q & running_i;
    if (accept) begin
      running_d[req_i.id] = 1'b1;
    end
    // Oldest issued entry finishes on B
    done_d = '0;
    if (b_fire) begin
      done_d[entries_q[commit_pnt_q].id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      running_q    <= '0;
      done_q       <= '0;
      req_ready_q  <= 1'b1;
    end else begin
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= bump(issue_pnt_q);
      end
      if (b_fire) begin
        commit_pnt_q <= bump(commit_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      running_q    <= running_d;
      done_q       <= done_d;
      // Ready for next cycle follows the updated fill level
      req_ready_q  <= (commit_cnt_d != CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      entries_q[accept_pnt_q] <= req_i;
    end
  end

  // Commit never passes an entry that is still issuing
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_cnt_q >= issue_cnt_q)
    else $error("store queue committed ahead of issue");

  // Accept never lands on an entry still waiting for commit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (accept_pnt_q != commit_pnt_q || commit_cnt_q == '0))
    else $error("store queue accepted while full");

endmodule

// File: design/vstu_consts.svh
// Sizes of the store unit; lane words and W beats are both 64 bits, and vl must fit VSTU_VL_W
`ifndef VSTU_CONSTS_SVH
`define VSTU_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath geometry
//////////////////////////////////////////////////////////////////////

// Lanes feeding the register-file word
`define VSTU_NR_LANES 4
// Bytes per lane operand
`define VSTU_LANE_BYTES 8
// Bytes per W beat
`define VSTU_BUS_BYTES 8

//////////////////////////////////////////////////////////////////////
// Instruction bookkeeping
//////////////////////////////////////////////////////////////////////

// Entries in the instruction queue
`define VSTU_QUEUE_DEPTH 4
// Distinct instruction ids from the sequencer
`define VSTU_NR_VINSN 8
// Width of the vector length field
`define VSTU_VL_W 8

`endif

// File: design/vstu_pkg.sv
// Types shared by the store unit and its testbench; widths follow vstu_consts.svh
`include "vstu_consts.svh"

package vstu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction types
  //////////////////////////////////////////////////////////////////////

  // Element width, also the shift from element count to byte count
  typedef enum logic [1:0] {
    VSEW_8  = 2'd0,
    VSEW_16 = 2'd1,
    VSEW_32 = 2'd2,
    VSEW_64 = 2'd3
  } vsew_e;

  // Instruction id as issued by the sequencer
  typedef logic [$clog2(`VSTU_NR_VINSN)-1:0] vinsn_id_t;

  // Store instruction as queued
  typedef struct packed {
    vinsn_id_t             id;
    logic [`VSTU_VL_W-1:0] vl;
    vsew_e                 vsew;
  } store_req_t;

  // One bit per id, used for running and done vectors
  typedef logic [`VSTU_NR_VINSN-1:0] done_vec_t;

  //////////////////////////////////////////////////////////////////////
  // Datapath types
  //////////////////////////////////////////////////////////////////////

  // Joined lane operands, lane n at bytes 8n up to 8n+7
  typedef logic [`VSTU_NR_LANES*`VSTU_LANE_BYTES*8-1:0] vrf_word_t;

  // Burst length in beats minus one, as on an AXI AW channel
  typedef logic [7:0] burst_len_t;

  typedef struct packed {
    burst_len_t len;
  } burst_req_t;

  // W beat
  typedef struct packed {
    logic [`VSTU_BUS_BYTES*8-1:0] data;
    logic [`VSTU_BUS_BYTES-1:0]   strb;
    logic                         last;
  } w_beat_t;

endpackage

// File: design/vstu_top.sv
// Store unit top; bursts must match each store's beat count and B arrives after its last beat
`timescale 1ns/1ps
`include "vstu_consts.svh"

module vstu_top (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // Sequencer
  input  vstu_pkg::store_req_t                             req_i,
  input  logic                                             req_valid_i,
  output logic                                             req_ready_o,
  input  vstu_pkg::done_vec_t                              running_i,
  // Lanes
  input  logic [`VSTU_NR_LANES-1:0][`VSTU_LANE_BYTES*8-1:0] operand_i,
  input  logic [`VSTU_NR_LANES-1:0]                        operand_valid_i,
  output logic [`VSTU_NR_LANES-1:0]                        operand_ready_o,
  // Address generator
  input  vstu_pkg::burst_req_t                             burst_i,
  input  logic                                             burst_valid_i,
  output logic                                             burst_ready_o,
  // Memory
  output vstu_pkg::w_beat_t                                w_o,
  output logic                                             w_valid_o,
  input  logic                                             w_ready_i,
  input  logic                                             b_valid_i,
  output logic                                             b_ready_o,
  // Status
  output logic                                             store_pending_o,
  output logic                                             store_complete_o,
  output vstu_pkg::done_vec_t                              done_o
);
  import vstu_pkg::*;

  // Queue to packer
  store_req_t issue;
  logic       issue_valid;
  logic       issue_done;

  // Buffer to packer
  vrf_word_t  word;
  logic       word_valid;
  logic       word_ready;

  store_insn_queue u_store_insn_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .running_i       (running_i),
    .issue_o         (issue),
    .issue_valid_o   (issue_valid),
    .issue_done_i    (issue_done),
    .b_valid_i       (b_valid_i),
    .b_ready_o       (b_ready_o),
    .store_pending_o (store_pending_o),
    .store_complete_o(store_complete_o),
    .done_o          (done_o)
  );

  lane_operand_buffer u_lane_operand_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .word_o         (word),
    .word_valid_o   (word_valid),
    .word_ready_i   (word_ready)
  );

  w_beat_packer u_w_beat_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_valid_i(issue_valid),
    .issue_done_o (issue_done),
    .word_i       (word),
    .word_valid_i (word_valid),
    .word_ready_o (word_ready),
    .burst_i      (burst_i),
    .burst_valid_i(burst_valid_i),
    .burst_ready_o(burst_ready_o),
    .w_o          (w_o),
    .w_valid_o    (w_valid_o),
    .w_ready_i    (w_ready_i)
  );

endmodule

// File: design/w_beat_packer.sv
// Bursts are bus-aligned and end with their instruction; vl must be nonzero
`timescale 1ns/1ps
`include "vstu_consts.svh"

module w_beat_packer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Instruction being issued
  input  vstu_pkg::store_req_t issue_i,
  input  logic                 issue_valid_i,
  output logic                 issue_done_o,
  // Joined lane operands
  input  vstu_pkg::vrf_word_t  word_i,
  input  logic                 word_valid_i,
  output logic                 word_ready_o,
  // Bursts from the address generator
  input  vstu_pkg::burst_req_t burst_i,
  input  logic                 burst_valid_i,
  output logic                 burst_ready_o,
  // W channel
  output vstu_pkg::w_beat_t    w_o,
  output logic                 w_valid_o,
  input  logic                 w_ready_i
);
  import vstu_pkg::*;

  localparam int unsigned WORD_BYTES = `VSTU_NR_LANES * `VSTU_LANE_BYTES;
  localparam int unsigned BUS_BYTES  = `VSTU_BUS_BYTES;
  localparam int unsigned PNT_W      = $clog2(WORD_BYTES) + 1;
  // Enough for vl shifted by the widest element
  localparam int unsigned BYTES_W    = `VSTU_VL_W + 3;

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  // Remaining bytes are valid only after the first beat of a store
  logic               loaded_q, loaded_d;
  logic [BYTES_W-1:0] rem_q, rem_d;
  // Byte position inside the current word
  logic [PNT_W-1:0]   vrf_pnt_q, vrf_pnt_d;
  // Beats already sent in the current burst
  burst_len_t         beat_cnt_q, beat_cnt_d;

  logic [BYTES_W-1:0] insn_left;
  logic [BYTES_W-1:0] word_left;
  logic [BYTES_W-1:0] valid_bytes;
  logic               beat_fire;

  w_beat_t beat_d;
  w_beat_t w_q;
  logic    w_valid_q;

  // New store starts from its full byte count
  assign insn_left = loaded_q ? rem_q : (BYTES_W'(issue_i.vl) << issue_i.vsew);
  assign word_left = BYTES_W'(WORD_BYTES) - BYTES_W'(vrf_pnt_q);

  // Output slot free or being drained this cycle
  assign beat_fire = issue_valid_i && word_valid_i && burst_valid_i &&
                     (!w_valid_q || w_ready_i);

  //////////////////////////////////////////////////////////////////////
  // Beat formation
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_pack
    // Least of word, instruction and bus bytes
    valid_bytes = (word_left < insn_left) ? word_left : insn_left;
    if (valid_bytes > BYTES_W'(BUS_BYTES)) begin
      valid_bytes = BYTES_W'(BUS_BYTES);
    end

    // Sequential copy, unused bytes stay zero
    beat_d = '0;
    for (int b = 0; b < BUS_BYTES; b++) begin
      if (BYTES_W'(b) < valid_bytes) begin
        beat_d.data[8*b +: 8] = word_i[8*(int'(vrf_pnt_q) + b) +: 8];
        beat_d.strb[b]        = 1'b1;
      end
    end
    beat_d.last = (beat_cnt_q == burst_i.len);

    rem_d         = rem_q;
    loaded_d      = loaded_q;
    vrf_pnt_d     = vrf_pnt_q;
    beat_cnt_d    = beat_cnt_q;
    word_ready_o  = 1'b0;
    burst_ready_o = 1'b0;
    issue_done_o  = 1'b0;

    if (beat_fire) begin
      rem_d     = insn_left - valid_bytes;
      loaded_d  = 1'b1;
      vrf_pnt_d = vrf_pnt_q + PNT_W'(valid_bytes);

      // Burst ends, ask for the next one
      if (beat_d.last) begin
        burst_ready_o = 1'b1;
        beat_cnt_d    = '0;
      end else begin
        beat_cnt_d = beat_cnt_q + 1'b1;
      end

      // Word used up, or nothing left of this store
      if (vrf_pnt_d == PNT_W'(WORD_BYTES) || rem_d == '0) begin
        word_ready_o = 1'b1;
        vrf_pnt_d    = '0;
      end

      // Final beat of the store
      if (rem_d == '0) begin
        issue_done_o = 1'b1;
        loaded_d     = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q   <= 1'b0;
      rem_q      <= '0;
      vrf_pnt_q  <= '0;
      beat_cnt_q <= '0;
      w_valid_q  <= 1'b0;
    end else begin
      loaded_q   <= loaded_d;
      rem_q      <= rem_d;
      vrf_pnt_q  <= vrf_pnt_d;
      beat_cnt_q <= beat_cnt_d;
      if (beat_fire) begin
        w_valid_q <= 1'b1;
      end else if (w_ready_i) begin
        w_valid_q <= 1'b0;
      end
    end
  end

  // Output beat register
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      w_q <= beat_d;
    end
  end

  assign w_o       = w_q;
  assign w_valid_o = w_valid_q;

  // Held beat must not move under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (w_valid_o && !w_ready_i) |=> (w_valid_o && $stable(w_o)))
    else $error("W beat changed under back-pressure");

endmodule

// File: testbench/tb_clk_gen.sv
// Free-running 8 ns clock; reset is held low for the first 10 rising edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release reset just after the tenth edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// File: testbench/tb_vstu.sv
// Random stores with random lane, burst, W and B timing; vl is kept to 256 bytes per store
`timescale 1ns/1ps
`include "vstu_consts.svh"

module tb_vstu;
  import vstu_pkg::*;

  localparam int unsigned N_INSN = 24;
  localparam int unsigned LANES  = `VSTU_NR_LANES;
  localparam int unsigned DEPTH  = `VSTU_QUEUE_DEPTH;
  localparam int unsigned LIMIT  = 200 * N_INSN + 100;

  logic clk, rst_n;
  store_req_t req;
  logic req_valid, req_ready;
  done_vec_t running, done;
  logic [LANES-1:0][63:0] operand;
  logic [LANES-1:0] operand_valid, operand_ready;
  burst_req_t burst;
  logic burst_valid, burst_ready;
  w_beat_t w;
  logic w_valid, w_ready, b_valid, b_ready;
  logic store_pending, store_complete;

  // Reference model state
  store_req_t insn_q [N_INSN];
  vrf_word_t  word_q [$];
  burst_len_t burst_q [$];
  w_beat_t    beat_q [$];
  bit         end_q [$];
  vinsn_id_t  commit_q [$];
  int unsigned lane_idx [LANES];
  int unsigned burst_idx, req_idx, b_owed, outstanding, errors, cycles, beats_seen;
  done_vec_t id_busy, running_tb, done_exp, dropped;
  bit saw_full, saw_blocked;

  tb_clk_gen u_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

  vstu_top u_vstu_top (
    .clk_i(clk), .rst_ni(rst_n),
    .req_i(req), .req_valid_i(req_valid), .req_ready_o(req_ready), .running_i(running),
    .operand_i(operand), .operand_valid_i(operand_valid), .operand_ready_o(operand_ready),
    .burst_i(burst), .burst_valid_i(burst_valid), .burst_ready_o(burst_ready),
    .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_ready_o(b_ready),
    .store_pending_o(store_pending), .store_complete_o(store_complete), .done_o(done)
  );

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and expected stream
  //////////////////////////////////////////////////////////////////////

  task automatic build_stimulus();
    int unsigned bytes, maxvl, start, nb, left, n, used;
    vrf_word_t word;
    w_beat_t beat;
    for (int i = 0; i < N_INSN; i++) begin
      if (i == 0) begin
        insn_q[i].id = vinsn_id_t'($urandom % `VSTU_NR_VINSN);
      end else if (i < DEPTH) begin
        // First fill of the queue needs distinct ids, B waits for it
        insn_q[i].id = insn_q[i-1].id + 1'b1;
      end else if (i == DEPTH) begin
        // Same id as the first store, still running when this one arrives
        insn_q[i].id = insn_q[0].id;
      end else begin
        insn_q[i].id = vinsn_id_t'($urandom % `VSTU_NR_VINSN);
      end
      insn_q[i].vsew = vsew_e'($urandom % 4);
      maxvl = 256 >> insn_q[i].vsew;
      if (maxvl > 255) maxvl = 255;
      insn_q[i].vl = 8'(1 + $urandom % maxvl);
      bytes = int'(insn_q[i].vl) << insn_q[i].vsew;
      start = beat_q.size();
      used  = 0;
      // Words fill sequentially, the last one only partly
      while (used < bytes) begin
        for (int k = 0; k < 8; k++) word[32*k +: 32] = $urandom;
        word_q.push_back(word);
        for (int o = 0; o < 32 && used < bytes; o += 8) begin
          beat = '0;
          for (int b = 0; b < 8 && used < bytes; b++) begin
            beat.data[8*b +: 8] = word[8*(o + b) +: 8];
            beat.strb[b]        = 1'b1;
            used++;
          end
          beat_q.push_back(beat);
          end_q.push_back(used == bytes);
        end
      end
      // Random burst split over this store's beats
      nb   = beat_q.size() - start;
      left = nb;
      while (left > 0) begin
        n = 1 + $urandom % ((left < 8) ? left : 8);
        burst_q.push_back(burst_len_t'(n - 1));
        beat_q[start + nb - left + n - 1].last = 1'b1;
        left -= n;
      end
    end
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the stores did not all complete", cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    bit lane_fire [LANES];
    bit burst_fire, acc, w_fire, b_fire;
    done_vec_t done_next;
    w_beat_t exp_beat;
    errors = 0;
    void'($urandom(22));
    req = '0; req_valid = 1'b0; running = '0; operand = '0; operand_valid = '0;
    burst = '0; burst_valid = 1'b0; w_ready = 1'b0; b_valid = 1'b0;
    burst_idx = 0; req_idx = 0; b_owed = 0; outstanding = 0; beats_seen = 0;
    id_busy = '0; running_tb = '0; done_exp = '0; saw_full = 0; saw_blocked = 0;
    for (int l = 0; l < LANES; l++) lane_idx[l] = 0;
    build_stimulus();
    wait (rst_n === 1'b1);

    while (!(req_idx == N_INSN && beat_q.size() == 0 && commit_q.size() == 0 &&
             b_owed == 0 && done_exp == '0)) begin
      ////////////////////////////////////////////////////////////////////
      // Sample at the falling edge, where every signal is settled
      ////////////////////////////////////////////////////////////////////
      @(negedge clk);
      for (int l = 0; l < LANES; l++) lane_fire[l] = operand_valid[l] && operand_ready[l];
      burst_fire = burst_valid && burst_ready;
      acc        = req_valid && req_ready && !id_busy[req.id];
      w_fire     = w_valid && w_ready;
      b_fire     = b_valid && b_ready;

      check_value("req_ready", outstanding != DEPTH, req_ready);
      check_value("store_pending", outstanding != 0, store_pending);
      check_value("done", done_exp, done);
      // B is only offered for a store whose final beat has left, so it must be taken
      check_value("store_complete", b_valid, store_complete);
      if (outstanding == DEPTH) saw_full = 1;
      if (req_valid && outstanding != DEPTH && id_busy[req.id]) saw_blocked = 1;
      dropped = done_exp;

      if (w_fire) begin
        if (beat_q.size() == 0) begin
          errors++;
          $display("Extra W beat arrived after the expected stream ended");
        end else begin
          exp_beat = beat_q.pop_front();
          check_value("w_data", exp_beat.data, w.data);
          check_value("w_strb", exp_beat.strb, w.strb);
          check_value("w_last", exp_beat.last, w.last);
          beats_seen++;
          if (end_q.pop_front()) b_owed++;
        end
      end

      // Commit of the oldest store shows on done one cycle later
      done_next = '0;
      if (b_fire) begin
        done_next[commit_q.pop_front()] = 1'b1;
        b_owed--;
      end
      id_busy = (id_busy & running) | (acc ? done_vec_t'(1 << req.id) : '0);
      if (acc) commit_q.push_back(req.id);
      outstanding = outstanding + acc - b_fire;
      done_exp = done_next;

      ////////////////////////////////////////////////////////////////////
      // Drive shortly after the rising edge
      ////////////////////////////////////////////////////////////////////
      @(posedge clk);
      #1;
      for (int l = 0; l < LANES; l++) begin
        if (lane_fire[l]) begin
          lane_idx[l]++;
          operand_valid[l] = 1'b0;
        end
        if (!operand_valid[l] && lane_idx[l] < word_q.size() && $urandom % 4 != 0) begin
          operand_valid[l] = 1'b1;
          operand[l]       = word_q[lane_idx[l]][64*l +: 64];
        end
      end
      if (burst_fire) begin
        burst_idx++;
        burst_valid = 1'b0;
      end
      if (!burst_valid && burst_idx < burst_q.size() && $urandom % 3 != 0) begin
        burst_valid = 1'b1;
        burst.len   = burst_q[burst_idx];
      end
      if (acc) begin
        req_idx++;
        req_valid = 1'b0;
      end
      // Sequencer retires finished ids for at least one cycle
      running_tb = running_tb & ~dropped;
      if (!req_valid && req_idx < N_INSN && $urandom % 3 != 0) begin
        req_valid = 1'b1;
        req       = insn_q[req_idx];
      end
      if (req_valid && !dropped[req.id]) running_tb[req.id] = 1'b1;
      running = running_tb;
      w_ready = ($urandom % 3 != 0);
      if (b_fire) b_valid = 1'b0;
      // Hold B back until the queue has been filled once
      if (!b_valid && b_owed > 0 && (saw_full || req_idx == N_INSN) && $urandom % 2 != 0) begin
        b_valid = 1'b1;
      end
    end

    if (!saw_full) begin
      errors++;
      $display("Instruction queue never reached four outstanding stores");
    end
    if (!saw_blocked) begin
      errors++;
      $display("No request ever waited on a running id while the queue had room");
    end
    $display("Closing summary: %0d errors, %0d beats checked", errors, beats_seen);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+design
design/vstu_pkg.sv
design/store_insn_queue.sv
design/lane_operand_buffer.sv
design/w_beat_packer.sv
design/vstu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_vstu.sv
